//--- iwmRegPkg.sv
`default_nettype none

package iwmRegPkg;

	// Data bytes and register bytes on the CPU bus
	typedef logic [7:0] iwmByte;

	// Soft-switch index taken from address bits 3..1
	typedef logic [2:0] switchIdx;

	// ====================
	// Soft-switch map
	// ====================
	localparam switchIdx SW_PHASE0 = 3'd0;
	localparam switchIdx SW_PHASE1 = 3'd1;
	localparam switchIdx SW_PHASE2 = 3'd2;
	localparam switchIdx SW_PHASE3 = 3'd3;
	localparam switchIdx SW_MOTOR  = 3'd4;
	localparam switchIdx SW_DRIVE  = 3'd5;
	localparam switchIdx SW_Q6     = 3'd6;
	localparam switchIdx SW_Q7     = 3'd7;

	// Mode register bits
	localparam int MODE_LATCH     = 0;
	localparam int MODE_ASYNC     = 1;
	localparam int MODE_TIMER_OFF = 2;
	localparam int MODE_FAST      = 3;
	localparam int MODE_8MHZ      = 4;

	// Status register bits, low five carry the mode bits
	localparam int STAT_SENSE  = 7;
	localparam int STAT_ENABLE = 5;

	// Write-handshake register bits
	localparam int HS_BUF_EMPTY   = 7;
	localparam int HS_NO_UNDERRUN = 6;

endpackage

`default_nettype wire

//--- iwmTimingPkg.sv
`default_nettype none

package iwmTimingPkg;

	// Count of fclk cycles inside one bit cell
	typedef logic [5:0] bitTime;

	// Table index, {fast, 8 MHz}
	typedef logic [1:0] cellSel;

	// Count of fclk cycles for the data MSB clear
	typedef logic [3:0] clearTime;

	// ====================
	// Bit-cell timing
	// ====================
	// Order is slow 7M, slow 8M, fast 7M, fast 8M
	// Slow values are doubled since the timers run on fclk
	localparam bitTime ONE_THRESH  [4] = '{6'd14, 6'd16, 6'd7, 6'd8};
	localparam bitTime ZERO_THRESH [4] = '{6'd42, 6'd48, 6'd21, 6'd24};

	// Last timer value of a write cell, period minus one
	localparam bitTime WRITE_CELL  [4] = '{6'd27, 6'd31, 6'd13, 6'd15};

	// Write timer start value, seven CLK periods into slow mode
	localparam bitTime WRITE_START = 6'd14;

	// Cycles from a data read to the MSB clear
	localparam clearTime MSB_CLEAR_DELAY = 4'd14;

	// Mode after reset: latch, async and timer-off set
	localparam iwmRegPkg::iwmByte MODE_RESET = 8'h07;

endpackage

`default_nettype wire

//--- iwmIfs.sv
`timescale 1ns/100ps
`default_nettype none

// Soft-switch state and the mode bits the datapath needs
interface switchIf;
	logic [3:0] phase;
	logic       motorOn;
	logic       driveSelect;
	logic       q6;
	logic       q7;
	logic       modeFast;
	logic       mode8Mhz;
	logic [4:0] modeLow5;

	modport decode (output phase, motorOn, driveSelect, q6, q7, modeFast, mode8Mhz, modeLow5);
	modport user (input phase, motorOn, driveSelect, q6, q7, modeFast, mode8Mhz, modeLow5);
endinterface

// Strobes and state around the shared data buffer
interface dataRegIf;
	import iwmRegPkg::*;

	// Read deserializer hands over a framed byte
	logic   readLatch;
	iwmByte readByte;
	// One-shot CPU data write
	logic   cpuWrite;
	iwmByte cpuByte;
	// Write serializer pulls the buffer
	logic   loadReq;
	logic   noUnderrun;
	// Buffer contents and write flag
	iwmByte buffer;
	logic   bufEmpty;

	modport store (input readLatch, readByte, cpuWrite, cpuByte, loadReq, noUnderrun,
		output buffer, bufEmpty);
	modport reader (output readLatch, readByte, input buffer, bufEmpty, noUnderrun);
	modport serializer (output loadReq, noUnderrun, input buffer, bufEmpty);
	modport cpu (output cpuWrite, cpuByte);
endinterface

`default_nettype wire

//--- iwmSwitchDecode.sv
`timescale 1ns/100ps
`default_nettype none

module iwmSwitchDecode (
	input  logic              fclk,
	input  logic              nRES,
	input  logic [3:0]        addr,
	input  logic              nDevSelect,
	input  iwmRegPkg::iwmByte dataIn,
	switchIf.decode           sw,
	dataRegIf.cpu             dr
);
	import iwmRegPkg::*;
	import iwmTimingPkg::*;

	logic [3:0] phase;
	logic       motorOn;
	logic       driveSelect;
	logic       q6;
	logic       q7;
	logic       nDevPrev;
	// Only the five low mode bits have a function or a readback
	logic [4:0] modeReg;

	// Write pipeline, register then settle then one-shot block
	logic       wrReg;
	logic       wrSettle;
	logic       wrDone;
	logic       wrStrobe;
	logic       writeCond;

	// Q7, Q6 and A0 high during a selected access
	assign writeCond = ~nDevSelect & q7 & q6 & addr[0];
	assign wrStrobe  = wrSettle & ~wrDone;

	// ====================
	// Soft switches
	// ====================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			phase       <= 4'b0000;
			motorOn     <= 1'b0;
			driveSelect <= 1'b0;
			q6          <= 1'b0;
			q7          <= 1'b0;
			nDevPrev    <= 1'b1;
		end else begin
			nDevPrev <= nDevSelect;
			// Level sampled, later cycles overwrite an early glitch
			if (!nDevSelect) begin
				case (addr[3:1])
					SW_PHASE0: phase[0]    <= addr[0];
					SW_PHASE1: phase[1]    <= addr[0];
					SW_PHASE2: phase[2]    <= addr[0];
					SW_PHASE3: phase[3]    <= addr[0];
					SW_MOTOR:  motorOn     <= addr[0];
					SW_DRIVE:  driveSelect <= addr[0];
					default: ;
				endcase
			end
			// Q6 and Q7 differ only in A0, so take them once at select fall
			if (nDevPrev && !nDevSelect) begin
				case (addr[3:1])
					SW_Q6:   q6 <= addr[0];
					SW_Q7:   q7 <= addr[0];
					default: ;
				endcase
			end
		end
	end

	// ====================
	// Write strobe and mode
	// ====================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			wrReg    <= 1'b0;
			wrSettle <= 1'b0;
			wrDone   <= 1'b0;
			modeReg  <= MODE_RESET[4:0];
		end else begin
			wrReg    <= writeCond;
			wrSettle <= wrReg;
			wrDone   <= wrSettle;
			// Motor off routes the strobe to the mode register
			if (wrStrobe && !motorOn)
				modeReg <= dataIn[MODE_8MHZ:MODE_LATCH];
		end
	end

	// Motor on routes it to the data buffer
	assign dr.cpuWrite = wrStrobe & motorOn;
	assign dr.cpuByte  = dataIn;

	assign sw.phase       = phase;
	assign sw.motorOn     = motorOn;
	assign sw.driveSelect = driveSelect;
	assign sw.q6          = q6;
	assign sw.q7          = q7;
	assign sw.modeFast    = modeReg[MODE_FAST];
	assign sw.mode8Mhz    = modeReg[MODE_8MHZ];
	assign sw.modeLow5    = modeReg;

endmodule

`default_nettype wire

//--- iwmDataRegister.sv
`timescale 1ns/100ps
`default_nettype none

module iwmDataRegister (
	input  logic       fclk,
	input  logic       nRES,
	input  logic [3:0] addr,
	input  logic       nDevSelect,
	switchIf.user      sw,
	dataRegIf.store    dr
);
	import iwmRegPkg::*;
	import iwmTimingPkg::*;

	iwmByte   buffer;
	logic     bufEmpty;
	clearTime clearTimer;
	logic     readMode;
	logic     cpuLoad;
	logic     clearMsb;

	// Data register reads happen with Q7 and Q6 both low
	assign readMode = ~sw.q7 & ~sw.q6;
	// CPU writes are dropped once the serializer has underrun
	assign cpuLoad  = dr.cpuWrite & dr.noUnderrun;
	assign clearMsb = readMode && (clearTimer == MSB_CLEAR_DELAY);

	// ====================
	// Shared buffer
	// ====================
	// CPU write wins over a read latch, which wins over the MSB clear
	always_ff @(posedge fclk) begin
		if (cpuLoad)
			buffer <= dr.cpuByte;
		else if (dr.readLatch)
			buffer <= dr.readByte;
		else if (clearMsb)
			buffer[7] <= 1'b0;
	end

	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			bufEmpty   <= 1'b1;
			clearTimer <= '0;
		end else begin
			// Fresh CPU byte beats a serializer pull in the same cycle
			if (cpuLoad)
				bufEmpty <= 1'b0;
			else if (dr.loadReq)
				bufEmpty <= 1'b1;

			// MSB clear timer, frozen outside the data read mode
			if (readMode) begin
				if (clearTimer == '0) begin
					if (!nDevSelect && !addr[0] && buffer[7])
						clearTimer <= clearTime'(1);
				end else if (clearMsb) begin
					clearTimer <= '0;
				end else begin
					clearTimer <= clearTimer + 1'b1;
				end
			end
		end
	end

	assign dr.buffer   = buffer;
	assign dr.bufEmpty = bufEmpty;

endmodule

`default_nettype wire

//--- iwmReadShifter.sv
`timescale 1ns/100ps
`default_nettype none

module iwmReadShifter (
	input  logic     fclk,
	input  logic     nRES,
	input  logic     rdData,
	switchIf.user    sw,
	dataRegIf.reader dr
);
	import iwmRegPkg::*;
	import iwmTimingPkg::*;

	logic [1:0] rdSync;
	logic       fallEdge;
	bitTime     bitTimer;
	bitTime     oneThresh;
	bitTime     zeroThresh;
	cellSel     cellIdx;
	iwmByte     shifter;
	iwmByte     shiftBase;
	logic       readLatch;

	// Thresholds follow the fast and 8 MHz mode bits
	assign cellIdx    = {sw.modeFast, sw.mode8Mhz};
	assign oneThresh  = ONE_THRESH[cellIdx];
	assign zeroThresh = ZERO_THRESH[cellIdx];

	// Bit 1 is the older sample
	assign fallEdge = rdSync[1] & ~rdSync[0];

	// MSB framing, a byte is complete once bit 7 is set
	assign readLatch = ~sw.q7 & shifter[7];
	// Framed byte leaves the shifter as the next one starts
	assign shiftBase = readLatch ? '0 : shifter;

	// Two-flop synchronizer, idle line is high
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES)
			rdSync <= 2'b11;
		else
			rdSync <= {rdSync[0], rdData};
	end

	// ====================
	// Bit-cell measurement
	// ====================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			bitTimer <= '0;
			shifter  <= '0;
		end else if (sw.q7) begin
			// Write mode holds the deserializer idle
			bitTimer <= '0;
			shifter  <= '0;
		end else if (fallEdge) begin
			// Edge late enough in the cell is a 1, an early one is noise
			bitTimer <= '0;
			if (bitTimer >= oneThresh)
				shifter <= {shiftBase[6:0], 1'b1};
			else
				shifter <= shiftBase;
		end else if (bitTimer >= zeroThresh) begin
			// No edge for a cell and a half is a 0
			shifter  <= {shiftBase[6:0], 1'b0};
			bitTimer <= oneThresh;
		end else begin
			shifter  <= shiftBase;
			bitTimer <= bitTimer + 1'b1;
		end
	end

	assign dr.readLatch = readLatch;
	assign dr.readByte  = shifter;

endmodule

`default_nettype wire

//--- iwmWriteShifter.sv
`timescale 1ns/100ps
`default_nettype none

module iwmWriteShifter (
	input  logic         fclk,
	input  logic         nRES,
	output logic         wrData,
	switchIf.user        sw,
	dataRegIf.serializer dr
);
	import iwmRegPkg::*;
	import iwmTimingPkg::*;

	bitTime     cellTimer;
	bitTime     cellEnd;
	logic [2:0] bitCount;
	iwmByte     shifter;
	logic       q7Prev;
	logic       noUnderrun;
	logic       cellDone;
	logic       byteDone;

	assign cellEnd  = WRITE_CELL[{sw.modeFast, sw.mode8Mhz}];
	assign cellDone = sw.q7 & q7Prev & (cellTimer == cellEnd);
	// Every eighth cell the next byte is due
	assign byteDone = cellDone & (bitCount == 3'd7);

	// Pull strobe, data register sets its empty flag on the same edge
	assign dr.loadReq = byteDone & ~dr.bufEmpty;

	// ====================
	// Serializer
	// ====================
	always_ff @(posedge fclk or negedge nRES) begin
		if (!nRES) begin
			cellTimer  <= '0;
			bitCount   <= 3'd7;
			shifter    <= '0;
			q7Prev     <= 1'b0;
			noUnderrun <= 1'b1;
			wrData     <= 1'b1;
		end else begin
			q7Prev <= sw.q7;
			if (!sw.q7) begin
				// Leaving write mode clears underrun and idles the line
				noUnderrun <= 1'b1;
				wrData     <= 1'b1;
			end else if (!q7Prev) begin
				// Write mode entry, partial first cell then the first load
				cellTimer <= WRITE_START;
				bitCount  <= 3'd7;
				shifter   <= 8'hFF;
			end else begin
				if (cellDone) begin
					cellTimer <= '0;
					if (byteDone) begin
						bitCount <= 3'd0;
						if (!dr.bufEmpty)
							shifter <= dr.buffer;
						else
							noUnderrun <= 1'b0;
					end else begin
						bitCount <= bitCount + 1'b1;
						shifter  <= {shifter[6:0], 1'b0};
					end
				end else begin
					cellTimer <= cellTimer + 1'b1;
				end

				// A 1 bit is a transition early in its cell
				if (!noUnderrun)
					wrData <= 1'b1;
				else if (cellTimer == bitTime'(1) && shifter[7])
					wrData <= ~wrData;
			end
		end
	end

	assign dr.noUnderrun = noUnderrun;

endmodule

`default_nettype wire

//--- iwmBusRead.sv
`timescale 1ns/100ps
`default_nettype none

module iwmBusRead (
	input  logic              sense,
	output iwmRegPkg::iwmByte dataOut,
	output logic              nWrReq,
	output logic              nEnbl1,
	output logic              nEnbl2,
	switchIf.user             sw,
	dataRegIf.reader          dr
);
	import iwmRegPkg::*;

	logic   enbl1;
	logic   enbl2;
	logic   enableActive;
	iwmByte statusByte;
	iwmByte handshakeByte;

	// Drive enables straight from motor and drive select
	assign enbl1        = sw.motorOn & ~sw.driveSelect;
	assign enbl2        = sw.motorOn & sw.driveSelect;
	assign enableActive = enbl1 | enbl2;
	assign nEnbl1       = ~enbl1;
	assign nEnbl2       = ~enbl2;

	// Write request needs write mode, no underrun and a live drive
	assign nWrReq = ~(sw.q7 & dr.noUnderrun & enableActive);

	always_comb begin
		// Status byte
		statusByte              = '0;
		statusByte[STAT_SENSE]  = sense;
		statusByte[STAT_ENABLE] = enableActive;
		statusByte[4:0]         = sw.modeLow5;
		// Handshake byte
		handshakeByte                 = '0;
		handshakeByte[HS_BUF_EMPTY]   = dr.bufEmpty;
		handshakeByte[HS_NO_UNDERRUN] = dr.noUnderrun;
		// Register select by Q7 and Q6
		case ({sw.q7, sw.q6})
			2'b00:   dataOut = dr.buffer;
			2'b01:   dataOut = statusByte;
			2'b10:   dataOut = handshakeByte;
			default: dataOut = 8'hFF;
		endcase
	end

endmodule

`default_nettype wire

//--- iwmTop.sv
`timescale 1ns/100ps
`default_nettype none

module iwmTop (
	// CPU bus
	input  logic              fclk,
	input  logic              nRES,
	input  logic [3:0]        addr,
	input  logic              nDevSelect,
	input  iwmRegPkg::iwmByte dataIn,
	output iwmRegPkg::iwmByte dataOut,
	// Drive side
	output logic              wrData,
	output logic [3:0]        phase,
	output logic              nWrReq,
	output logic              nEnbl1,
	output logic              nEnbl2,
	input  logic              sense,
	input  logic              rdData
);

	switchIf  swBus ();
	dataRegIf drBus ();

	iwmSwitchDecode uDecode (
		.fclk       (fclk),
		.nRES       (nRES),
		.addr       (addr),
		.nDevSelect (nDevSelect),
		.dataIn     (dataIn),
		.sw         (swBus.decode),
		.dr         (drBus.cpu)
	);

	iwmDataRegister uDataReg (
		.fclk       (fclk),
		.nRES       (nRES),
		.addr       (addr),
		.nDevSelect (nDevSelect),
		.sw         (swBus.user),
		.dr         (drBus.store)
	);

	iwmReadShifter uRead (
		.fclk   (fclk),
		.nRES   (nRES),
		.rdData (rdData),
		.sw     (swBus.user),
		.dr     (drBus.reader)
	);

	iwmWriteShifter uWrite (
		.fclk   (fclk),
		.nRES   (nRES),
		.wrData (wrData),
		.sw     (swBus.user),
		.dr     (drBus.serializer)
	);

	iwmBusRead uBusRead (
		.sense   (sense),
		.dataOut (dataOut),
		.nWrReq  (nWrReq),
		.nEnbl1  (nEnbl1),
		.nEnbl2  (nEnbl2),
		.sw      (swBus.user),
		.dr      (drBus.reader)
	);

	// Phase lines go straight out to the drive
	assign phase = swBus.phase;

endmodule

`default_nettype wire

//--- tbIwm.sv
`timescale 1ns/100ps
`default_nettype none

module tbIwm;
	import iwmRegPkg::*;
	import iwmTimingPkg::*;

	// Slow 7 MHz bit cell in fclk cycles
	localparam int CELL_CYCLES = 28;

	logic       fclk;
	logic       nRES;
	logic [3:0] addr;
	logic       nDevSelect;
	iwmByte     dataIn;
	iwmByte     dataOut;
	logic       wrData;
	logic [3:0] phase;
	logic       nWrReq;
	logic       nEnbl1;
	logic       nEnbl2;
	logic       sense;
	logic       rdData;

	logic [31:0] lfsrState;
	int          checkErrors;
	int          testsPassed;
	int          testsFailed;
	// wrData transitions seen while the write request is active
	int          wrEdges = 0;
	logic        wrDataPrev = 1'b1;

	iwmTop uut (
		.fclk       (fclk),
		.nRES       (nRES),
		.addr       (addr),
		.nDevSelect (nDevSelect),
		.dataIn     (dataIn),
		.dataOut    (dataOut),
		.wrData     (wrData),
		.phase      (phase),
		.nWrReq     (nWrReq),
		.nEnbl1     (nEnbl1),
		.nEnbl2     (nEnbl2),
		.sense      (sense),
		.rdData     (rdData)
	);

	// 100 ns clock
	initial begin
		fclk = 1'b0;
		forever #50 fclk = ~fclk;
	end

	// Counts flux transitions on the write line, sampled mid-cycle
	always @(negedge fclk) begin
		if (!nWrReq && wrData !== wrDataPrev)
			wrEdges = wrEdges + 1;
		wrDataPrev = wrData;
	end

	// ====================
	// Reference helpers
	// ====================
	// Fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit taken
	task automatic randomByte(output iwmByte value);
		int i;
		for (i = 0; i < 8; i++) begin
			lfsrState = lfsrNext(lfsrState);
			value = {value[6:0], lfsrState[0]};
		end
	endtask

	function automatic int countOnes(input iwmByte value);
		int ones;
		int i;
		ones = 0;
		for (i = 0; i < 8; i++)
			ones += int'(value[i]);
		return ones;
	endfunction

	// Sense, a zero, enable, then mode low five
	function automatic iwmByte statusValue(input logic senseIn, input logic enable,
		input logic [4:0] mode5);
		iwmByte value;
		value              = '0;
		value[STAT_SENSE]  = senseIn;
		value[STAT_ENABLE] = enable;
		value[4:0]         = mode5;
		return value;
	endfunction

	function automatic iwmByte handshakeValue(input logic empty, input logic noUnderrun);
		iwmByte value;
		value                 = '0;
		value[HS_BUF_EMPTY]   = empty;
		value[HS_NO_UNDERRUN] = noUnderrun;
		return value;
	endfunction

	// ====================
	// Bus and disk models
	// ====================
	// One selected access, 7 cycles long
	task automatic busAccess(input logic [3:0] a, input iwmByte d);
		@(posedge fclk);
		#10;
		addr       = a;
		dataIn     = d;
		nDevSelect = 1'b0;
		repeat (7) @(posedge fclk);
		#10;
		nDevSelect = 1'b1;
	endtask

	// Same access, dataOut taken mid-cycle once Q6 and Q7 have settled
	task automatic readAccess(input logic [3:0] a, output iwmByte value);
		@(posedge fclk);
		#10;
		addr       = a;
		nDevSelect = 1'b0;
		repeat (3) @(posedge fclk);
		@(negedge fclk);
		value = dataOut;
		repeat (4) @(posedge fclk);
		#10;
		nDevSelect = 1'b1;
	endtask

	// Q6 on, Q7 on, then the write itself with the same byte
	task automatic writeRegister(input iwmByte d);
		busAccess({SW_Q6, 1'b1}, d);
		busAccess({SW_Q7, 1'b1}, d);
		busAccess({SW_Q7, 1'b1}, d);
	endtask

	// A 1 is a short low pulse at the cell start, a 0 is no edge
	task automatic sendCell(input logic value);
		@(posedge fclk);
		#10;
		if (value)
			rdData = 1'b0;
		repeat (2) @(posedge fclk);
		#10;
		rdData = 1'b1;
		repeat (CELL_CYCLES - 3) @(posedge fclk);
	endtask

	// ====================
	// Checking
	// ====================
	task automatic checkEq(input string testName, input string what,
		input iwmByte expected, input iwmByte actual);
		assert (actual === expected) else begin
			$display("ERR %s %s: expected %h actual %h", testName, what, expected, actual);
			checkErrors++;
		end
	endtask

	task automatic finishTest(input string name, input int startErrors);
		if (checkErrors == startErrors) begin
			testsPassed++;
			$display("PASS %s", name);
		end else begin
			testsFailed++;
			$display("FAIL %s, %0d failed checks", name, checkErrors - startErrors);
		end
	endtask

	// ====================
	// Tests
	// ====================
	task automatic testReset();
		int     startErrors;
		iwmByte value;
		startErrors = checkErrors;
		// nWrReq, nEnbl1, nEnbl2, wrData all idle high
		checkEq("reset", "drive lines", 8'h0F, {4'b0000, nWrReq, nEnbl1, nEnbl2, wrData});
		checkEq("reset", "phase", 8'h00, {4'b0000, phase});
		readAccess({SW_Q6, 1'b1}, value);
		checkEq("reset", "status", statusValue(sense, 1'b0, MODE_RESET[4:0]), value);
		finishTest("reset", startErrors);
	endtask

	task automatic testSwitches();
		int     startErrors;
		int     i;
		iwmByte value;
		startErrors = checkErrors;
		for (i = 0; i < 4; i++) begin
			busAccess({switchIdx'(i), 1'b1}, 8'h00);
			checkEq("switches", "phase on", 8'(1 << i), {4'b0000, phase});
			busAccess({switchIdx'(i), 1'b0}, 8'h00);
			checkEq("switches", "phase off", 8'h00, {4'b0000, phase});
		end
		// Enables shown as {nEnbl2, nEnbl1}
		busAccess({SW_MOTOR, 1'b1}, 8'h00);
		busAccess({SW_DRIVE, 1'b0}, 8'h00);
		checkEq("switches", "drive 1 enables", 8'h02, {6'b000000, nEnbl2, nEnbl1});
		readAccess({SW_Q6, 1'b1}, value);
		checkEq("switches", "drive 1 status", statusValue(sense, 1'b1, MODE_RESET[4:0]), value);
		busAccess({SW_DRIVE, 1'b1}, 8'h00);
		checkEq("switches", "drive 2 enables", 8'h01, {6'b000000, nEnbl2, nEnbl1});
		readAccess({SW_Q6, 1'b1}, value);
		checkEq("switches", "drive 2 status", statusValue(sense, 1'b1, MODE_RESET[4:0]), value);
		busAccess({SW_MOTOR, 1'b0}, 8'h00);
		busAccess({SW_DRIVE, 1'b0}, 8'h00);
		checkEq("switches", "motor off enables", 8'h03, {6'b000000, nEnbl2, nEnbl1});
		finishTest("switches", startErrors);
	endtask

	task automatic testModeRegister();
		int     startErrors;
		iwmByte mode;
		iwmByte value;
		startErrors = checkErrors;
		sense = 1'b0;
		// Motor is off so every strobe lands in the mode register
		repeat (4) begin
			randomByte(mode);
			writeRegister(mode);
			busAccess({SW_Q7, 1'b0}, 8'h00);
			readAccess({SW_Q6, 1'b1}, value);
			checkEq("mode", "status", statusValue(sense, 1'b0, mode[4:0]), value);
		end
		sense = 1'b1;
		finishTest("mode", startErrors);
	endtask

	task automatic testReadPath();
		int     startErrors;
		int     i;
		int     waited;
		iwmByte diskByte;
		iwmByte value;
		startErrors = checkErrors;
		// Slow 7 MHz, then Q7 and Q6 off for the data register
		writeRegister(8'h00);
		busAccess({SW_Q7, 1'b0}, 8'h00);
		busAccess({SW_Q6, 1'b0}, 8'h00);
		randomByte(diskByte);
		diskByte[7] = 1'b1;
		repeat (3) sendCell(1'b0);
		// MSB goes first
		for (i = 7; i >= 0; i--)
			sendCell(diskByte[i]);
		waited = 0;
		while (dataOut[7] !== 1'b1 && waited < int'(ZERO_THRESH[0])) begin
			@(negedge fclk);
			waited++;
		end
		assert (dataOut[7] === 1'b1) else begin
			$display("Read path: no framed byte reached the data register in time");
			checkErrors++;
		end
		checkEq("read path", "data register", diskByte, dataOut);
		readAccess({SW_Q6, 1'b0}, value);
		checkEq("read path", "data read", diskByte, value);
		// The read access already took 7 cycles
		waited = 7;
		while (dataOut[7] !== 1'b0 && waited < int'(MSB_CLEAR_DELAY) + 4) begin
			@(negedge fclk);
			waited++;
		end
		assert (dataOut[7] === 1'b0) else begin
			$display("Read path: data register MSB was not cleared after the read");
			checkErrors++;
		end
		checkEq("read path", "after clear", {1'b0, diskByte[6:0]}, dataOut);
		finishTest("read path", startErrors);
	endtask

	task automatic testWritePath();
		int     startErrors;
		int     startEdges;
		int     waited;
		iwmByte wrByte;
		iwmByte value;
		startErrors = checkErrors;
		startEdges  = wrEdges;
		busAccess({SW_MOTOR, 1'b1}, 8'h00);
		busAccess({SW_DRIVE, 1'b0}, 8'h00);
		randomByte(wrByte);
		writeRegister(wrByte);
		// Q6 off selects the handshake register while Q7 stays on
		readAccess({SW_Q6, 1'b0}, value);
		checkEq("write path", "handshake after load", handshakeValue(1'b1, 1'b1), value);
		// Next load finds the buffer empty, nWrReq rises
		waited = 0;
		while (nWrReq !== 1'b1 && waited < (int'(WRITE_CELL[0]) + 1) * 10) begin
			@(negedge fclk);
			waited++;
		end
		assert (nWrReq === 1'b1) else begin
			$display("Write path: write request never dropped after the byte was sent");
			checkErrors++;
		end
		readAccess({SW_Q6, 1'b0}, value);
		checkEq("write path", "transitions", 8'(countOnes(wrByte)), 8'(wrEdges - startEdges));
		checkEq("write path", "handshake after underrun", handshakeValue(1'b1, 1'b0), value);
		checkEq("write path", "write request", 8'h01, {7'b0000000, nWrReq});
		busAccess({SW_Q7, 1'b0}, 8'h00);
		busAccess({SW_MOTOR, 1'b0}, 8'h00);
		finishTest("write path", startErrors);
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		nRES        = 1'b0;
		addr        = 4'h0;
		nDevSelect  = 1'b1;
		dataIn      = 8'h00;
		sense       = 1'b1;
		rdData      = 1'b1;
		lfsrState   = 32'd90329;
		checkErrors = 0;
		testsPassed = 0;
		testsFailed = 0;
		repeat (5) @(posedge fclk);
		#10;
		nRES = 1'b1;

		testReset();
		testSwitches();
		testModeRegister();
		testReadPath();
		testWritePath();

		$display("Tests passed: %0d, tests failed: %0d, failed checks: %0d",
			testsPassed, testsFailed, checkErrors);
		if (testsFailed == 0 && checkErrors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
iwmRegPkg.sv
iwmTimingPkg.sv
iwmIfs.sv
iwmSwitchDecode.sv
iwmDataRegister.sv
iwmReadShifter.sv
iwmWriteShifter.sv
iwmBusRead.sv
iwmTop.sv
tbIwm.sv

//--- Makefile
VERILATOR  = verilator
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal
TOP        = tbIwm
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
PASS_MSG   = All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
